//--- filelist.f
+incdir+src
src/uart_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/cmd_sender.sv
src/uart.sv
tb/uart_clkgen.sv
tb/uart_asserts.sv
tb/uart_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -o pipefail

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f --top-module uart_tb -o uart_sim \
  && ./obj_dir/uart_sim 2>&1 | tee "$LOG" \
  || { echo "build or simulation error"; exit 1; }

grep -qF '*** FAILED ***' "$LOG" && { echo "simulation reported failure"; exit 1; } \
  || { echo "simulation passed"; exit 0; }

//--- src/cmd_sender.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module cmd_sender (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::cmd_t  cmd_in,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output uart_pkg::byte_t tx_byte,
  output logic            tx_start,
  input  logic            tx_done
);

  import uart_pkg::*;

  cmd_state_t state;
  cmd_t       cmd_q;
  logic       start_q;
  logic       accept;

  assign accept  = (state == CMD_IDLE) && cmd_vld;
  assign cmd_rdy = (state == CMD_IDLE);

  // low byte starts in the cycle the high frame ends
  assign tx_start = start_q | ((state == CMD_HIGH) && tx_done);

  always_comb begin
    if (state == CMD_HIGH && !tx_done) begin
      tx_byte = cmd_q[`UART_CMD_WIDTH-1 -: `UART_BYTE_WIDTH];
    end else begin
      tx_byte = cmd_q[`UART_BYTE_WIDTH-1:0];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= CMD_IDLE;
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
      case (state)
        CMD_IDLE: begin
          if (cmd_vld) begin
            state <= CMD_HIGH;
          end
        end
        CMD_HIGH: begin
          if (tx_done) begin
            state <= CMD_LOW;
          end
        end
        CMD_LOW: begin
          if (tx_done) begin
            state <= CMD_IDLE;
          end
        end
        default: begin
          state <= CMD_IDLE;
        end
      endcase
    end
  end

  // command held for both frames
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd_in;
    end
  end

endmodule

`default_nettype wire

//--- src/uart.sv
`timescale 1ns/10ps
`default_nettype none

module uart (
  input  logic               clk,
  input  logic               rst_n,
  input  uart_pkg::cmd_t     cmd_in,
  input  logic               cmd_vld,
  output logic               cmd_rdy,
  input  logic               rx,
  output logic               tx,
  output logic               read_rdy,
  output uart_pkg::rx_word_t read_data
);

  import uart_pkg::*;

  byte_t tx_byte;
  logic  tx_start;
  logic  tx_done;

  cmd_sender u_cmd_sender (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_in   (cmd_in),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_done  (tx_done)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  // receive path goes straight to the ports
  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_word  (read_data),
    .rx_valid (read_rdy)
  );

endmodule

`default_nettype wire

//--- src/uart_params.svh
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

// system clock and line rate
`define UART_CLK_HZ 50000000
`define UART_BAUD 115200

// clock cycles per bit, 434 at the rates above
`define UART_BAUD_DIV (`UART_CLK_HZ / `UART_BAUD)

// command and frame data widths
`define UART_CMD_WIDTH 16
`define UART_BYTE_WIDTH 8

`endif

//--- src/uart_pkg.sv
`default_nettype none

`include "uart_params.svh"

package uart_pkg;

  typedef logic [`UART_CMD_WIDTH-1:0] cmd_t;
  typedef logic [`UART_BYTE_WIDTH-1:0] byte_t;

  // top bit is the error flag, low bits the data
  typedef logic [`UART_BYTE_WIDTH:0] rx_word_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_t;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_t;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_HIGH,
    CMD_LOW
  } cmd_state_t;

endpackage

`default_nettype wire

//--- src/uart_rx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module uart_rx (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               rx,
  output uart_pkg::rx_word_t rx_word,
  output logic               rx_valid
);

  import uart_pkg::*;

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIV - 1);
  localparam logic [CNT_W-1:0] CNT_HALF = CNT_W'(`UART_BAUD_DIV / 2 - 1);

  rx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             fall;
  logic             bit_end;
  logic             err;
  byte_t            shift;
  logic             parity_bit;

  // two-flop synchronizer plus edge history
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign fall    = rx_prev & ~rx_sync;
  assign bit_end = (cnt == CNT_LAST);

  // parity must come out odd, stop must be high
  assign err = ~(^{shift, parity_bit}) | ~rx_sync;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= RX_IDLE;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_word  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          cnt <= '0;
          if (fall) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (cnt == CNT_HALF) begin
            cnt     <= '0;
            bit_idx <= '0;
            // glitch if the line is back high at mid-bit
            state   <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= RX_PARITY;
            end else begin
              bit_idx <= bit_idx + 3'd1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_PARITY: begin
          if (bit_end) begin
            cnt   <= '0;
            state <= RX_STOP;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_end) begin
            cnt      <= '0;
            state    <= RX_IDLE;
            rx_word  <= {err, shift};
            rx_valid <= 1'b1;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= RX_IDLE;
          cnt   <= '0;
        end
      endcase
    end
  end

  // mid-bit sampling, data arrives lsb first
  always_ff @(posedge clk) begin
    if (bit_end && state == RX_DATA) begin
      shift <= {rx_sync, shift[7:1]};
    end
    if (bit_end && state == RX_PARITY) begin
      parity_bit <= rx_sync;
    end
  end

endmodule

`default_nettype wire

//--- src/uart_tx.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::byte_t tx_byte,
  input  logic            tx_start,
  output logic            tx_done,
  output logic            tx
);

  import uart_pkg::*;

  localparam int CNT_W = $clog2(`UART_BAUD_DIV);
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`UART_BAUD_DIV - 1);

  tx_state_t        state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  byte_t            shift;
  logic             parity;
  logic             bit_end;

  assign bit_end = (cnt == CNT_LAST);

  // last cycle of the stop bit
  assign tx_done = (state == TX_STOP) && bit_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else if (tx_start) begin
      // start bit goes out on this edge
      state   <= TX_START;
      cnt     <= '0;
      bit_idx <= '0;
      tx      <= 1'b0;
    end else if (state != TX_IDLE) begin
      if (bit_end) begin
        cnt <= '0;
        case (state)
          TX_START: begin
            state <= TX_DATA;
            tx    <= shift[0];
          end
          TX_DATA: begin
            if (bit_idx == 3'd7) begin
              state <= TX_PARITY;
              tx    <= parity;
            end else begin
              bit_idx <= bit_idx + 3'd1;
              tx      <= shift[0];
            end
          end
          TX_PARITY: begin
            state <= TX_STOP;
            tx    <= 1'b1;
          end
          TX_STOP: begin
            state <= TX_IDLE;
            tx    <= 1'b1;
          end
          default: begin
            state <= TX_IDLE;
            tx    <= 1'b1;
          end
        endcase
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // data shifter, lsb first
  always_ff @(posedge clk) begin
    if (tx_start) begin
      shift  <= tx_byte;
      // odd parity over the data bits
      parity <= ~^tx_byte;
    end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

//--- tb/uart_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module uart_asserts (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  // line idles high while no command is in flight
  a_idle_tx: assert property (@(posedge clk) disable iff (!rst_n) cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  a_rdy_pulse: assert property (@(posedge clk) disable iff (!rst_n) read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles");

  // busy only after an accepted command
  a_rdy_fall: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cmd_rdy) |-> $past(cmd_vld && cmd_rdy))
    else $error("cmd_rdy fell without an accepted command");

endmodule

bind uart uart_asserts u_uart_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .cmd_vld  (cmd_vld),
  .cmd_rdy  (cmd_rdy),
  .tx       (tx),
  .read_rdy (read_rdy)
);

`default_nettype wire

//--- tb/uart_clkgen.sv
`timescale 1ns/10ps
`default_nettype none

module uart_clkgen (
  output logic clk,
  output logic rst_n
);

  // 8 ns period
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- tb/uart_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "uart_params.svh"

module uart_tb;

  import uart_pkg::*;

  localparam int BIT_CYC    = `UART_BAUD_DIV;
  localparam int WAIT_LIMIT = 4 * 11 * BIT_CYC;
  localparam int NUM_ROWS   = 12;

  typedef enum {W_RST, W_RDY, W_TX, W_READ} watch_t;

  // inject, extra cmd_vld while busy, bad parity, stop value, expected flag, command
  typedef struct packed {
    logic inject;
    logic extra_vld;
    logic bad_par;
    logic stop_val;
    logic exp_err;
    cmd_t cmd;
  } row_t;

  logic        clk;
  logic        rst_n;
  cmd_t        cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        rx;
  logic        tx;
  logic        read_rdy;
  rx_word_t    read_data;
  logic        use_inject;
  logic        inj_line;
  row_t        rows [NUM_ROWS];
  logic [15:0] lfsr_q;
  int          checks;
  int          value_errs;
  int          timeouts;

  uart_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

  // far end is the loopback or the frame generator
  assign rx = use_inject ? inj_line : tx;

  uart UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .rx        (rx),
    .tx        (tx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

  // galois lfsr stepped once per bit
  function automatic cmd_t rand_cmd();
    cmd_t c;
    for (int i = 0; i < `UART_CMD_WIDTH; i++) begin
      c[i]   = lfsr_q[0];
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return c;
  endfunction

  task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input rx_word_t got, input rx_word_t exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      value_errs++;
      $display("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  function automatic logic probe(input watch_t w);
    case (w)
      W_RST:   return rst_n;
      W_RDY:   return cmd_rdy;
      W_TX:    return tx;
      default: return read_rdy;
    endcase
  endfunction

  task automatic wait_until(input watch_t w, input logic level, input string what);
    int n;
    n = 0;
    @(negedge clk);
    while (probe(w) !== level && n < WAIT_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (probe(w) !== level) begin
      timeouts++;
      $display("timeout while waiting for %s", what);
    end
  endtask

  task automatic pulse_cmd(input cmd_t c);
    @(posedge clk);
    #1 cmd_in = c;
    cmd_vld = 1'b1;
    @(posedge clk);
    #1 cmd_vld = 1'b0;
  endtask

  // decode one tx frame at mid-bit
  task automatic capture_frame(output byte_t data);
    logic par;
    wait_until(W_TX, 1'b0, "start bit on tx");
    repeat (BIT_CYC / 2) @(negedge clk);
    check_bit("tx start bit", tx, 1'b0);
    for (int i = 0; i < `UART_BYTE_WIDTH; i++) begin
      repeat (BIT_CYC) @(negedge clk);
      data[i] = tx;
    end
    repeat (BIT_CYC) @(negedge clk);
    par = tx;
    check_bit("tx parity odd", ^{data, par}, 1'b1);
    repeat (BIT_CYC) @(negedge clk);
    check_bit("tx stop bit", tx, 1'b1);
  endtask

  task automatic collect_word(output rx_word_t w);
    wait_until(W_READ, 1'b1, "read_rdy");
    w = read_data;
  endtask

  // start, data lsb first, parity, stop, then two idle bits
  task automatic send_frame(input byte_t data, input logic par, input logic stop_val);
    logic [10:0] bits;
    bits = {stop_val, par, data, 1'b0};
    for (int i = 0; i < 11; i++) begin
      inj_line = bits[i];
      repeat (BIT_CYC) @(posedge clk);
      #1;
    end
    inj_line = 1'b1;
    repeat (2 * BIT_CYC) @(posedge clk);
  endtask

  initial begin
    row_t     row;
    byte_t    hi;
    byte_t    lo;
    rx_word_t w_hi;
    rx_word_t w_lo;
    logic     quiet;

    cmd_in     = '0;
    cmd_vld    = 1'b0;
    use_inject = 1'b0;
    inj_line   = 1'b1;
    checks     = 0;
    value_errs = 0;
    timeouts   = 0;
    lfsr_q     = 16'd30582;

    rows[0]  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 16'hA55A};
    rows[1]  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 16'h0000};
    rows[2]  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 16'hFFFF};
    rows[3]  = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 16'h1234};
    rows[4]  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, rand_cmd()};
    rows[5]  = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, rand_cmd()};
    rows[6]  = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 16'h00A5};
    rows[7]  = '{1'b1, 1'b0, 1'b1, 1'b1, 1'b1, 16'h003C};
    rows[8]  = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 16'h00F0};
    rows[9]  = '{1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 16'h0081};
    rows[10] = '{1'b1, 1'b0, 1'b0, 1'b1, 1'b0, rand_cmd()};
    rows[11] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, rand_cmd()};

    wait_until(W_RST, 1'b1, "reset release");
    check_bit("tx after reset", tx, 1'b1);
    check_bit("cmd_rdy after reset", cmd_rdy, 1'b1);
    check_bit("read_rdy after reset", read_rdy, 1'b0);
    check_word("read_data after reset", read_data, '0);

    foreach (rows[r]) begin
      row = rows[r];
      if (!row.inject) begin
        fork
          begin
            wait_until(W_RDY, 1'b1, "cmd_rdy");
            pulse_cmd(row.cmd);
            // busy for two frames plus the launch cycle
            repeat (2 * 11 * BIT_CYC + 1) @(negedge clk);
            check_bit("cmd_rdy during two frames", cmd_rdy, 1'b0);
            @(negedge clk);
            check_bit("cmd_rdy after two frames", cmd_rdy, 1'b1);
          end
          begin
            capture_frame(hi);
            capture_frame(lo);
          end
          begin
            collect_word(w_hi);
            collect_word(w_lo);
          end
          if (row.extra_vld) begin
            wait_until(W_RDY, 1'b0, "cmd_rdy to fall");
            repeat (3 * BIT_CYC) @(posedge clk);
            pulse_cmd(~row.cmd);
          end
        join
        check_cmd("tx frames", {hi, lo}, row.cmd);
        check_word("read_data high byte", w_hi, {1'b0, row.cmd[15:8]});
        check_word("read_data low byte", w_lo, {1'b0, row.cmd[7:0]});
        wait_until(W_RDY, 1'b1, "cmd_rdy after two frames");
        // a third frame would start within a bit time
        quiet = 1'b1;
        repeat (BIT_CYC) begin
          @(negedge clk);
          quiet = quiet & tx;
        end
        check_bit("tx idle after command", quiet, 1'b1);
      end else begin
        @(posedge clk);
        #1 use_inject = 1'b1;
        fork
          send_frame(row.cmd[7:0], row.bad_par ? ^row.cmd[7:0] : ~^row.cmd[7:0],
                     row.stop_val);
          collect_word(w_hi);
        join
        #1 use_inject = 1'b0;
        check_word("read_data injected", w_hi, {row.exp_err, row.cmd[7:0]});
      end
    end

    $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errs, timeouts);
    if (value_errs == 0 && timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
